//--- logic/avmm_defs.svh
/*
 * Widths and limits shared by the Avalon local-memory shim.
 * Included by the package and by any module that sizes logic from these values.
 */

`ifndef AVMM_DEFS_SVH
`define AVMM_DEFS_SVH

// ==============================
// Address and data
// ==============================

// Word address, one address per data beat
`define AVMM_ADDR_WIDTH 16

// Equal on the AFU and FIU sides
`define AVMM_DATA_WIDTH 32

// ==============================
// Burst counts
// ==============================

// AFU bursts go up to 16 beats, so the count needs 5 bits
`define AVMM_AFU_BURST_WIDTH 5

// The FIU side takes at most 4 beats per command
`define AVMM_FIU_BURST_WIDTH 3
`define AVMM_FIU_MAX_BURST 4

`endif

//--- logic/avmm_pkg.sv
/*
 * Request, response and state types for the Avalon local-memory shim.
 * Modules name these types with avmm_pkg:: in port lists and import the package in bodies.
 */

`include "avmm_defs.svh"

package avmm_pkg;

    // ==============================
    // Requests
    // ==============================

    // AFU-side request, burst count wide enough for the largest AFU burst
    // Only one of read or write may be high in a given cycle
    typedef struct packed {
        logic                             read;
        logic                             write;
        logic [`AVMM_ADDR_WIDTH-1:0]      address;
        logic [`AVMM_AFU_BURST_WIDTH-1:0] burstcount;
        logic [`AVMM_DATA_WIDTH-1:0]      writedata;
        logic [`AVMM_DATA_WIDTH/8-1:0]    byteenable;
    } avmm_afu_req_t;

    // FIU-side request, same fields with the narrower burst count
    typedef struct packed {
        logic                             read;
        logic                             write;
        logic [`AVMM_ADDR_WIDTH-1:0]      address;
        logic [`AVMM_FIU_BURST_WIDTH-1:0] burstcount;
        logic [`AVMM_DATA_WIDTH-1:0]      writedata;
        logic [`AVMM_DATA_WIDTH/8-1:0]    byteenable;
    } avmm_fiu_req_t;

    // ==============================
    // Responses and state
    // ==============================

    // Read data returns one beat per cycle with no back-pressure
    typedef struct packed {
        logic                        readdatavalid;
        logic [`AVMM_DATA_WIDTH-1:0] readdata;
    } avmm_rsp_t;

    // Burst mapper FSM
    // MAP_WRITE covers the data beats of a write burst, MAP_READ the extra read chunks
    typedef enum logic [1:0] {
        MAP_IDLE,
        MAP_WRITE,
        MAP_READ
    } map_state_e;

endpackage

//--- logic/avmm_burst_mapper.sv
/*
 * Cuts AFU bursts into FIU-sized chunks with a zero-latency request path.
 * Writes are split beat by beat; reads are reissued as several FIU commands
 * while the AFU is held off with waitrequest.
 */

`timescale 1ns/1ps

`include "avmm_defs.svh"

module avmm_burst_mapper
(
    input  logic                   clk,
    input  logic                   reset,

    input  avmm_pkg::avmm_afu_req_t afu_req,
    output logic                   afu_waitrequest,

    output avmm_pkg::avmm_fiu_req_t map_req,
    input  logic                   map_waitrequest
);

    import avmm_pkg::*;

    localparam int ADDR_W = `AVMM_ADDR_WIDTH;
    localparam int AFU_BW = `AVMM_AFU_BURST_WIDTH;
    localparam int FIU_BW = `AVMM_FIU_BURST_WIDTH;

    // The FIU limit in both counter widths
    localparam logic [AFU_BW-1:0] MAX_AFU = AFU_BW'(`AVMM_FIU_MAX_BURST);
    localparam logic [FIU_BW-1:0] MAX_FIU = FIU_BW'(`AVMM_FIU_MAX_BURST);

    // ==============================
    // State
    // ==============================

    map_state_e state;

    // Low in reset and for the first cycle after it, so the AFU sees one
    // cycle of waitrequest before the first request may go through
    logic ready_q;

    // For writes this is the address of the next data beat
    // For reads it is the address of the next chunk to issue
    logic [ADDR_W-1:0] run_addr;

    // Beats of the AFU burst that have not yet gone out
    logic [AFU_BW-1:0] beats_left;

    // Write data beats still owed to the current FIU chunk
    // Zero means the next write beat opens a new chunk
    logic [FIU_BW-1:0] chunk_left;

    // ==============================
    // Current chunk
    // ==============================

    logic [ADDR_W-1:0] cur_addr;
    logic [AFU_BW-1:0] cur_left;
    logic              new_chunk;
    logic              last_chunk;
    logic [FIU_BW-1:0] cur_len;
    logic [AFU_BW-1:0] cur_len_afu;
    logic              map_accept;

    // In idle the burst is described by the AFU request itself
    // Once a burst is under way the running registers take over
    assign cur_addr = (state == MAP_IDLE) ? afu_req.address : run_addr;
    assign cur_left = (state == MAP_IDLE) ? afu_req.burstcount : beats_left;

    // Every read command is a chunk header, and so is a write beat with nothing owed
    assign new_chunk = (state != MAP_WRITE) || (chunk_left == '0);

    // What is left fits in one FIU burst
    assign last_chunk = (cur_left <= MAX_AFU);

    // Chunk length is the smaller of the FIU limit and the remaining beats
    assign cur_len     = last_chunk ? cur_left[FIU_BW-1:0] : MAX_FIU;
    assign cur_len_afu = AFU_BW'(cur_len);

    // ==============================
    // Request path
    // ==============================

    // Reads are blocked in the middle of a write burst and writes in the
    // middle of a read split, so a stray command cannot cut into a burst
    always_comb
    begin
        map_req.read       = ready_q && afu_req.read && (state != MAP_WRITE);
        map_req.write      = ready_q && afu_req.write && (state != MAP_READ);
        map_req.address    = cur_addr;
        map_req.burstcount = cur_len;
        map_req.writedata  = afu_req.writedata;
        map_req.byteenable = afu_req.byteenable;
    end

    // The FIU side ignores address and burstcount on write data beats, so
    // driving the beat address and remaining length there is harmless

    assign map_accept = (map_req.read || map_req.write) && !map_waitrequest;

    // A read command is consumed only when its last chunk is accepted
    // Write beats follow the downstream waitrequest one for one
    assign afu_waitrequest = !ready_q || map_waitrequest || (afu_req.read && !last_chunk);

    // ==============================
    // FSM and counters
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= MAP_IDLE;
            ready_q <= 1'b0;
        end
        else
        begin
            ready_q <= 1'b1;

            if (map_accept)
            begin
                if (map_req.read)
                begin
                    state <= last_chunk ? MAP_IDLE : MAP_READ;
                end
                else
                begin
                    // Return to idle with the final data beat of the AFU burst
                    state <= (cur_left == AFU_BW'(1)) ? MAP_IDLE : MAP_WRITE;
                end
            end
        end
    end

    // Running address and beat counters of the burst under way
    always_ff @(posedge clk)
    begin
        if (map_accept)
        begin
            if (map_req.read)
            begin
                // Skip past the chunk just issued
                run_addr   <= cur_addr + ADDR_W'(cur_len);
                beats_left <= cur_left - cur_len_afu;
            end
            else
            begin
                run_addr   <= cur_addr + ADDR_W'(1);
                beats_left <= cur_left - AFU_BW'(1);

                // A header beat counts as the first beat of its own chunk
                if (new_chunk)
                begin
                    chunk_left <= cur_len - FIU_BW'(1);
                end
                else
                begin
                    chunk_left <= chunk_left - FIU_BW'(1);
                end
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    // A zero-beat burst would leave the counters wrapping through the FSM
    afu_burst_nonzero: assert property (@(posedge clk) disable iff (reset)
        (afu_req.read || afu_req.write) |-> (afu_req.burstcount != '0));

    // Every command header leaving the mapper must fit the FIU and carry at least one beat
    map_burst_limit: assert property (@(posedge clk) disable iff (reset)
        ((map_req.read || map_req.write) && new_chunk)
            |-> ((map_req.burstcount != '0) && (map_req.burstcount <= MAX_FIU)));

endmodule

//--- logic/avmm_reg_pipe.sv
/*
 * Timing stages between the burst mapper and the FIU port.
 * Requests pass through skid-buffered stages that honour waitrequest;
 * read responses pass through an equal number of plain registers.
 */

`timescale 1ns/1ps

module avmm_reg_pipe
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic                    clk,
    input  logic                    reset,

    input  avmm_pkg::avmm_fiu_req_t src_req,
    output logic                    src_waitrequest,
    output avmm_pkg::avmm_rsp_t     src_rsp,

    output avmm_pkg::avmm_fiu_req_t sink_req,
    input  logic                    sink_waitrequest,
    input  avmm_pkg::avmm_rsp_t     sink_rsp
);

    import avmm_pkg::*;

    // Index 0 is the source end of each chain and index N_REG_STAGES the sink end
    // With no stages both ends are the same element and the module is wires
    avmm_fiu_req_t stage_req  [N_REG_STAGES+1];
    logic          stage_wait [N_REG_STAGES+1];
    avmm_rsp_t     stage_rsp  [N_REG_STAGES+1];

    assign stage_req[0]  = src_req;
    assign src_waitrequest = stage_wait[0];
    assign sink_req      = stage_req[N_REG_STAGES];

    assign stage_wait[N_REG_STAGES] = sink_waitrequest;
    assign stage_rsp[N_REG_STAGES]  = sink_rsp;
    assign src_rsp                  = stage_rsp[0];

    genvar i;

    generate
        for (i = 0; i < N_REG_STAGES; i++)
        begin : stg
            // ==============================
            // Request skid stage
            // ==============================

            avmm_fiu_req_t out_q;
            avmm_fiu_req_t skid_q;
            logic          skid_full;
            logic          out_free;

            // The output slot can load when it is empty or being taken this cycle
            assign out_free = !(out_q.read || out_q.write) || !stage_wait[i+1];

            assign stage_req[i+1] = out_q;

            // Upstream waitrequest comes straight from a flop, which breaks
            // the combinational waitrequest path at every stage
            assign stage_wait[i] = skid_full;

            always_ff @(posedge clk)
            begin
                // Skid contents drain first so beat order is kept
                if (out_free)
                begin
                    out_q <= skid_full ? skid_q : stage_req[i];
                end
                else if (!skid_full)
                begin
                    // Output is stalled, so park whatever arrives in the skid
                    skid_q <= stage_req[i];
                end

                if (reset)
                begin
                    out_q.read  <= 1'b0;
                    out_q.write <= 1'b0;
                    skid_full   <= 1'b0;
                end
                else if (out_free)
                begin
                    skid_full <= 1'b0;
                end
                else if (stage_req[i].read || stage_req[i].write)
                begin
                    // A beat accepted while the output is stuck fills the skid
                    skid_full <= 1'b1;
                end
            end

            // ==============================
            // Response stage
            // ==============================

            avmm_rsp_t rsp_q;

            assign stage_rsp[i] = rsp_q;

            // readdatavalid has no back-pressure, so one flop per stage is enough
            always_ff @(posedge clk)
            begin
                rsp_q.readdata <= stage_rsp[i+1].readdata;

                if (reset)
                begin
                    rsp_q.readdatavalid <= 1'b0;
                end
                else
                begin
                    rsp_q.readdatavalid <= stage_rsp[i+1].readdatavalid;
                end
            end
        end
    endgenerate

    // The source must hold a stalled request until it is taken, otherwise
    // a beat can change under the skid register and be lost
    src_hold_stable: assert property (@(posedge clk) disable iff (reset)
        (src_req.read || src_req.write) && src_waitrequest |=> $stable(src_req));

endmodule

//--- logic/local_mem_as_avalon.sv
/*
 * Presents a platform local-memory port to an AFU as Avalon-MM.
 * Large AFU bursts are split for the FIU, then pass through N_REG_STAGES timing stages.
 */

`timescale 1ns/1ps

module local_mem_as_avalon
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic                    clk,
    input  logic                    reset,

    // AFU side
    input  avmm_pkg::avmm_afu_req_t afu_req,
    output logic                    afu_waitrequest,
    output avmm_pkg::avmm_rsp_t     afu_rsp,

    // FIU side
    output avmm_pkg::avmm_fiu_req_t fiu_req,
    input  logic                    fiu_waitrequest,
    input  avmm_pkg::avmm_rsp_t     fiu_rsp
);

    import avmm_pkg::*;

    // ==============================
    // Stage order
    // ==============================

    // Bursts are mapped first, right at the AFU edge, so that everything
    // downstream carries FIU-sized commands only. The timing stages then sit
    // between the mapper and the FIU, where their registered waitrequest
    // also cuts the combinational path back through the mapper.

    // Mapper output, already in FIU burst units
    avmm_fiu_req_t map_req;
    logic          map_waitrequest;

    avmm_burst_mapper burst_map
    (
        .clk             (clk),
        .reset           (reset),
        .afu_req         (afu_req),
        .afu_waitrequest (afu_waitrequest),
        .map_req         (map_req),
        .map_waitrequest (map_waitrequest)
    );

    // Read data is in FIU order, which is already AFU order, so the
    // pipe's response goes back to the AFU untouched
    avmm_reg_pipe
    #(
        .N_REG_STAGES (N_REG_STAGES)
    )
    mem_pipe
    (
        .clk              (clk),
        .reset            (reset),
        .src_req          (map_req),
        .src_waitrequest  (map_waitrequest),
        .src_rsp          (afu_rsp),
        .sink_req         (fiu_req),
        .sink_waitrequest (fiu_waitrequest),
        .sink_rsp         (fiu_rsp)
    );

endmodule

//--- bench/fiu_mem_model.sv
/*
 * Behavioural FIU memory that sinks the DUT's FIU port.
 * Waitrequest is random, and read data returns a fixed 3 cycles after each accepted command.
 */

`timescale 1ns/1ps

`include "avmm_defs.svh"

module fiu_mem_model
(
    input  logic                    clk,
    input  logic                    reset,
    input  avmm_pkg::avmm_fiu_req_t fiu_req,
    output logic                    fiu_waitrequest,
    output avmm_pkg::avmm_rsp_t     fiu_rsp
);

    import avmm_pkg::*;

    localparam int READ_LATENCY = 3;

    typedef struct packed {
        logic [31:0]                 due;
        logic [`AVMM_DATA_WIDTH-1:0] data;
    } rd_beat_t;

    logic [`AVMM_DATA_WIDTH-1:0] mem [65536];
    rd_beat_t                    rd_q [$];
    logic [`AVMM_ADDR_WIDTH-1:0] wr_addr;
    int                          wr_left;
    int                          cycle;
    int                          k;

    // Every word starts with a value built from its full address
    initial
    begin
        for (k = 0; k < 65536; k++)
        begin
            mem[k] = {k[15:0] ^ 16'h5a5a, ~k[15:0]};
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            fiu_waitrequest       <= 1'b1;
            fiu_rsp.readdatavalid <= 1'b0;
            fiu_rsp.readdata      <= '0;
            wr_left = 0;
            cycle   = 0;
        end
        else
        begin
            cycle = cycle + 1;

            // Address and burst count are only meaningful on the first write beat
            if (fiu_req.write && !fiu_waitrequest)
            begin
                if (wr_left == 0)
                begin
                    wr_addr = fiu_req.address;
                    wr_left = int'(fiu_req.burstcount);
                end
                mem[wr_addr] = fiu_req.writedata;
                wr_addr = wr_addr + 16'd1;
                wr_left = wr_left - 1;
            end

            // Read data is captured at acceptance and queued in order
            if (fiu_req.read && !fiu_waitrequest)
            begin
                for (k = 0; k < int'(fiu_req.burstcount); k++)
                begin
                    rd_q.push_back({32'(cycle + READ_LATENCY),
                                    mem[fiu_req.address + 16'(k)]});
                end
            end

            if ((rd_q.size() > 0) && (int'(rd_q[0].due) <= cycle))
            begin
                fiu_rsp.readdatavalid <= 1'b1;
                fiu_rsp.readdata      <= rd_q[0].data;
                void'(rd_q.pop_front());
            end
            else
            begin
                fiu_rsp.readdatavalid <= 1'b0;
            end

            // Stall about one cycle in four
            fiu_waitrequest <= ($urandom_range(3) == 0);
        end
    end

endmodule

//--- bench/mem_checker.sv
/*
 * Watches both sides of the DUT and compares chunks, write beats and read data.
 * The testbench opens each test through open_test and calls summary at the end.
 */

`timescale 1ns/1ps

`include "avmm_defs.svh"

module mem_checker
(
    input  logic                    clk,
    input  logic                    reset,
    input  avmm_pkg::avmm_afu_req_t afu_req,
    input  logic                    afu_waitrequest,
    input  avmm_pkg::avmm_rsp_t     afu_rsp,
    input  avmm_pkg::avmm_fiu_req_t fiu_req,
    input  logic                    fiu_waitrequest
);

    import avmm_pkg::*;

    localparam int MAX_TESTS = 64;

    // One expected FIU command, or one expected data beat
    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [4:0]  len;
        logic [31:0] data;
        logic [31:0] tag;
    } item_t;

    // ==============================
    // Bookkeeping
    // ==============================

    logic [31:0] shadow [65536];
    item_t       chunk_q [$];
    item_t       wbeat_q [$];
    item_t       rbeat_q [$];
    // Tests opened whose first AFU beat has not been accepted yet
    int          tag_q [$];
    string       names [MAX_TESTS];
    int          outstanding [MAX_TESTS];
    int          errs [MAX_TESTS];
    int          cur_tag;
    int          n_tests;
    int          error_count;
    int          failed_tests;
    int          pending_total;
    int          idle_errs;
    int          afu_wr_left;
    logic [15:0] afu_wr_addr;
    int          fiu_wr_left;
    logic [15:0] fiu_wr_addr;
    item_t       it;
    int          k;

    initial
    begin
        for (k = 0; k < 65536; k++)
        begin
            shadow[k] = {k[15:0] ^ 16'h5a5a, ~k[15:0]};
        end
        n_tests       = 0;
        error_count   = 0;
        failed_tests  = 0;
        pending_total = 0;
        idle_errs     = 0;
        cur_tag       = -1;
        afu_wr_left   = 0;
        fiu_wr_left   = 0;
    end

    // Registers a test and derives its FIU chunks from the splitting rule
    task automatic open_test(input int tag, input string name, input bit wr,
                             input logic [15:0] addr, input int len);
        item_t c;
        int    left;
        int    n;
        logic [15:0] a;
        names[tag] = name;
        errs[tag]  = 0;
        outstanding[tag] = len;
        left = len;
        a    = addr;
        while (left > 0)
        begin
            n = (left > `AVMM_FIU_MAX_BURST) ? `AVMM_FIU_MAX_BURST : left;
            c = '{wr: wr, addr: a, len: 5'(n), data: '0, tag: 32'(tag)};
            chunk_q.push_back(c);
            outstanding[tag] = outstanding[tag] + 1;
            a    = a + 16'(n);
            left = left - n;
        end
        pending_total = pending_total + outstanding[tag];
        tag_q.push_back(tag);
        n_tests = n_tests + 1;
    endtask

    task automatic mismatch(input int tag, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: %s expected %h actual %h", names[tag], what, exp, act);
        errs[tag]   = errs[tag] + 1;
        error_count = error_count + 1;
    endtask

    task automatic stray(input string what);
        $display("Unexpected %s with nothing outstanding", what);
        error_count = error_count + 1;
        if (n_tests == 0)
        begin
            idle_errs = idle_errs + 1;
        end
    endtask

    // The tag of a burst is fixed when its first AFU beat is accepted
    task automatic take_tag();
        if (tag_q.size() == 0)
        begin
            stray("AFU burst");
            cur_tag = 0;
        end
        else
        begin
            cur_tag = tag_q.pop_front();
        end
    endtask

    // A test line goes out when its last expected item has been seen
    task automatic retire(input int tag);
        outstanding[tag] = outstanding[tag] - 1;
        pending_total    = pending_total - 1;
        if (outstanding[tag] == 0)
        begin
            if (errs[tag] == 0)
                $display("test %s: ok", names[tag]);
            else
            begin
                $display("test %s: %0d mismatches", names[tag], errs[tag]);
                failed_tests = failed_tests + 1;
            end
        end
    endtask

    task automatic close_idle(input string name);
        if (idle_errs == 0)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: %0d stray beats", name, idle_errs);
            failed_tests = failed_tests + 1;
        end
    endtask

    task automatic summary();
        int t;
        for (t = 0; t < MAX_TESTS; t++)
        begin
            if ((t < n_tests) && (outstanding[t] > 0))
            begin
                $display("test %s: %0d beats or chunks never arrived", names[t],
                         outstanding[t]);
                failed_tests = failed_tests + 1;
            end
        end
        $display("%0d tests run, %0d failed, %0d errors", n_tests + 1, failed_tests,
                 error_count);
    endtask

    // ==============================
    // Monitors
    // ==============================

    always @(posedge clk)
    begin
        if (!reset)
        begin
            // Accepted AFU write beats feed the shadow and the beat queue
            if (afu_req.write && !afu_waitrequest)
            begin
                if (afu_wr_left == 0)
                begin
                    take_tag();
                    afu_wr_addr = afu_req.address;
                    afu_wr_left = int'(afu_req.burstcount);
                end
                shadow[afu_wr_addr] = afu_req.writedata;
                it = '{wr: 1'b1, addr: afu_wr_addr, len: 5'd1, data: afu_req.writedata,
                       tag: 32'(cur_tag)};
                wbeat_q.push_back(it);
                afu_wr_addr = afu_wr_addr + 16'd1;
                afu_wr_left = afu_wr_left - 1;
            end

            // An accepted AFU read fixes the data it must return
            if (afu_req.read && !afu_waitrequest)
            begin
                take_tag();
                for (k = 0; k < int'(afu_req.burstcount); k++)
                begin
                    it = '{wr: 1'b0, addr: afu_req.address + 16'(k), len: 5'd1,
                           data: shadow[afu_req.address + 16'(k)], tag: 32'(cur_tag)};
                    rbeat_q.push_back(it);
                end
            end

            // FIU command headers against the expected chunk list
            if ((fiu_req.read || (fiu_req.write && (fiu_wr_left == 0))) && !fiu_waitrequest)
            begin
                if (chunk_q.size() == 0)
                    stray("FIU command");
                else
                begin
                    it = chunk_q.pop_front();
                    if (it.wr != fiu_req.write)
                        mismatch(it.tag, "chunk write flag", 32'(it.wr), 32'(fiu_req.write));
                    if (it.addr != fiu_req.address)
                        mismatch(it.tag, "chunk address", 32'(it.addr), 32'(fiu_req.address));
                    if (it.len != 5'(fiu_req.burstcount))
                        mismatch(it.tag, "chunk burstcount", 32'(it.len),
                                 32'(fiu_req.burstcount));
                    retire(it.tag);
                end
                if (fiu_req.write)
                begin
                    fiu_wr_addr = fiu_req.address;
                    fiu_wr_left = int'(fiu_req.burstcount);
                end
            end

            // Every FIU write beat must match one AFU beat, in order
            if (fiu_req.write && !fiu_waitrequest)
            begin
                if (wbeat_q.size() == 0)
                    stray("FIU write beat");
                else
                begin
                    it = wbeat_q.pop_front();
                    if (it.addr != fiu_wr_addr)
                        mismatch(it.tag, "write beat address", 32'(it.addr), 32'(fiu_wr_addr));
                    if (it.data != fiu_req.writedata)
                        mismatch(it.tag, "write beat data", it.data, fiu_req.writedata);
                    retire(it.tag);
                end
                fiu_wr_addr = fiu_wr_addr + 16'd1;
                fiu_wr_left = fiu_wr_left - 1;
            end

            if (afu_rsp.readdatavalid)
            begin
                if (rbeat_q.size() == 0)
                    stray("read data beat");
                else
                begin
                    it = rbeat_q.pop_front();
                    if (it.data != afu_rsp.readdata)
                        mismatch(it.tag, "read data", it.data, afu_rsp.readdata);
                    retire(it.tag);
                end
            end
        end
    end

endmodule

//--- bench/tb_local_mem.sv
/*
 * Testbench top for the Avalon local-memory shim.
 * Applies a table of read and write bursts back to back and checks them through mem_checker.
 */

`timescale 1ns/1ps

`include "avmm_defs.svh"

module tb_local_mem;

    import avmm_pkg::*;

    localparam int          N_TESTS    = 14;
    localparam logic [31:0] SEED       = 32'h4ed407c0;
    localparam int          IDLE_WAIT  = 24;
    localparam bit          OP_WR      = 1'b1;
    localparam bit          OP_RD      = 1'b0;

    logic          clk;
    logic          reset;
    avmm_afu_req_t afu_req;
    logic          afu_waitrequest;
    avmm_rsp_t     afu_rsp;
    avmm_fiu_req_t fiu_req;
    logic          fiu_waitrequest;
    avmm_rsp_t     fiu_rsp;

    // ==============================
    // Stimulus table
    // ==============================

    string       t_name [N_TESTS];
    bit          t_op   [N_TESTS];
    logic [15:0] t_addr [N_TESTS];
    int          t_len  [N_TESTS];
    logic [31:0] t_base [N_TESTS];

    int limit;
    int cycles;
    int i;
    int b;

    task automatic set_entry(input int idx, input string name, input bit op,
                             input logic [15:0] addr, input int len, input logic [31:0] base);
        t_name[idx] = name;
        t_op[idx]   = op;
        t_addr[idx] = addr;
        t_len[idx]  = len;
        t_base[idx] = base;
    endtask

    // Drives one beat and returns once it will be taken on the next rising edge
    task automatic send_beat(input avmm_afu_req_t req);
        @(posedge clk);
        afu_req <= req;
        @(negedge clk);
        while (afu_waitrequest)
        begin
            @(negedge clk);
        end
    endtask

    local_mem_as_avalon #(.N_REG_STAGES(2)) dut_i
    (
        .clk             (clk),
        .reset           (reset),
        .afu_req         (afu_req),
        .afu_waitrequest (afu_waitrequest),
        .afu_rsp         (afu_rsp),
        .fiu_req         (fiu_req),
        .fiu_waitrequest (fiu_waitrequest),
        .fiu_rsp         (fiu_rsp)
    );

    fiu_mem_model mem_i
    (
        .clk             (clk),
        .reset           (reset),
        .fiu_req         (fiu_req),
        .fiu_waitrequest (fiu_waitrequest),
        .fiu_rsp         (fiu_rsp)
    );

    mem_checker chk_i
    (
        .clk             (clk),
        .reset           (reset),
        .afu_req         (afu_req),
        .afu_waitrequest (afu_waitrequest),
        .afu_rsp         (afu_rsp),
        .fiu_req         (fiu_req),
        .fiu_waitrequest (fiu_waitrequest)
    );

    always #4 clk = ~clk;

    // Hang guard, 64 cycles for every beat in the table
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= limit)
        begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            chk_i.summary();
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(SEED));
        clk     = 1'b0;
        reset   = 1'b1;
        afu_req = '0;
        cycles  = 0;

        set_entry(0,  "wr1",      OP_WR, 16'h0100, 1,  32'h1000_0000);
        set_entry(1,  "rd1",      OP_RD, 16'h0100, 1,  32'h0);
        set_entry(2,  "wr4",      OP_WR, 16'h0200, 4,  32'h2000_0000);
        set_entry(3,  "rd4",      OP_RD, 16'h0200, 4,  32'h0);
        set_entry(4,  "rd3_fill", OP_RD, 16'h0300, 3,  32'h0);
        set_entry(5,  "wr5",      OP_WR, 16'h0400, 5,  32'h3000_0000);
        set_entry(6,  "rd5",      OP_RD, 16'h0400, 5,  32'h0);
        set_entry(7,  "wr16",     OP_WR, 16'h0500, 16, 32'h4000_0000);
        set_entry(8,  "wr11",     OP_WR, 16'h0600, 11, 32'h5000_0000);
        set_entry(9,  "rd16",     OP_RD, 16'h0500, 16, 32'h0);
        set_entry(10, "rd11",     OP_RD, 16'h0600, 11, 32'h0);
        set_entry(11, "wr7",      OP_WR, 16'h0700, 7,  32'h6000_0000);
        set_entry(12, "rd7",      OP_RD, 16'h0700, 7,  32'h0);
        set_entry(13, "rd9_fill", OP_RD, 16'h8000, 9,  32'h0);

        limit = 64 * IDLE_WAIT;
        for (i = 0; i < N_TESTS; i++)
        begin
            limit = limit + 64 * t_len[i];
        end

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Nothing may move while the AFU side is quiet
        repeat (IDLE_WAIT) @(posedge clk);
        @(negedge clk);
        chk_i.close_idle("idle_after_reset");

        for (i = 0; i < N_TESTS; i++)
        begin
            chk_i.open_test(i, t_name[i], t_op[i], t_addr[i], t_len[i]);
            if (t_op[i] == OP_WR)
            begin
                for (b = 0; b < t_len[i]; b++)
                begin
                    send_beat('{read: 1'b0, write: 1'b1, address: t_addr[i] + 16'(b),
                                burstcount: 5'(t_len[i]), writedata: t_base[i] + 32'(b),
                                byteenable: 4'hf});
                end
            end
            else
            begin
                send_beat('{read: 1'b1, write: 1'b0, address: t_addr[i],
                            burstcount: 5'(t_len[i]), writedata: '0, byteenable: 4'hf});
            end
        end

        @(posedge clk);
        afu_req <= '0;

        while (chk_i.pending_total != 0)
        begin
            @(negedge clk);
        end
        repeat (16) @(negedge clk);

        chk_i.summary();
        if ((chk_i.error_count == 0) && (chk_i.failed_tests == 0))
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
logic/avmm_pkg.sv
logic/avmm_burst_mapper.sv
logic/avmm_reg_pipe.sv
logic/local_mem_as_avalon.sv
bench/fiu_mem_model.sv
bench/mem_checker.sv
bench/tb_local_mem.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_local_mem \
    -f files.f \
    -o sim_tb_local_mem

./obj_dir/sim_tb_local_mem > sim.log
cat sim.log

if grep -q "Test passed" sim.log; then
    exit 0
fi
exit 1
